//--- tlb_selftest_config.svh
// size, field width and pacing macros for the TLB self-test, included by the package and RTL
`ifndef TLB_SELFTEST_CONFIG_SVH
`define TLB_SELFTEST_CONFIG_SVH

// number of TLB entries
`define TLB_NUM 16

// entry field widths
`define TLB_VPPN_W 19
`define TLB_PPN_W 20
`define TLB_ASID_W 10
`define TLB_PS_W 6

// pacing counter reload, one sequencer step every reload+1 cycles
`define TLB_PACE_RELOAD 5

`endif

//--- tlb_pkg.sv
// derived widths and page-size codes shared by the TLB self-test RTL, imported per module
`include "tlb_selftest_config.svh"

package tlb_pkg;

    // entry index width
    localparam int tlb_idx_w = $clog2(`TLB_NUM);

    // page-size codes held in the ps field
    localparam logic [`TLB_PS_W-1:0] ps_4k = 12;
    localparam logic [`TLB_PS_W-1:0] ps_2m = 21;

    // board LED count
    localparam int led_w = 16;

endpackage

//--- tlb_ports_if.sv
// write, read and search port bundles between the TLB array and the self-test checkers
`timescale 1ns/1ps
`include "tlb_selftest_config.svh"

interface tlb_write_if;
    import tlb_pkg::*;

    logic                   we;
    logic [tlb_idx_w-1:0]   index;
    logic                   e;
    logic [`TLB_VPPN_W-1:0] vppn;
    logic [`TLB_PS_W-1:0]   ps;
    logic [`TLB_ASID_W-1:0] asid;
    logic                   g;
    logic [`TLB_PPN_W-1:0]  ppn0;
    logic [1:0]             plv0;
    logic [1:0]             mat0;
    logic                   d0;
    logic                   v0;
    logic [`TLB_PPN_W-1:0]  ppn1;
    logic [1:0]             plv1;
    logic [1:0]             mat1;
    logic                   d1;
    logic                   v1;

    modport source (output we, index, e, vppn, ps, asid, g,
                    ppn0, plv0, mat0, d0, v0, ppn1, plv1, mat1, d1, v1);
    modport target (input we, index, e, vppn, ps, asid, g,
                    ppn0, plv0, mat0, d0, v0, ppn1, plv1, mat1, d1, v1);
endinterface

interface tlb_read_if;
    import tlb_pkg::*;

    logic                   e;
    logic [tlb_idx_w-1:0]   index;
    logic [`TLB_VPPN_W-1:0] vppn;
    logic [`TLB_PS_W-1:0]   ps;
    logic [`TLB_ASID_W-1:0] asid;
    logic                   g;
    logic [`TLB_PPN_W-1:0]  ppn0;
    logic [1:0]             plv0;
    logic [1:0]             mat0;
    logic                   d0;
    logic                   v0;
    logic [`TLB_PPN_W-1:0]  ppn1;
    logic [1:0]             plv1;
    logic [1:0]             mat1;
    logic                   d1;
    logic                   v1;

    // read data follows index combinationally
    modport source (output index, input e, vppn, ps, asid, g,
                    ppn0, plv0, mat0, d0, v0, ppn1, plv1, mat1, d1, v1);
    modport target (input index, output e, vppn, ps, asid, g,
                    ppn0, plv0, mat0, d0, v0, ppn1, plv1, mat1, d1, v1);
endinterface

interface tlb_search_if;
    import tlb_pkg::*;

    logic [`TLB_VPPN_W-1:0] vppn;
    logic                   va_bit12;
    logic [`TLB_ASID_W-1:0] asid;
    logic                   found;
    logic [tlb_idx_w-1:0]   index;
    logic [`TLB_PPN_W-1:0]  ppn;
    logic [`TLB_PS_W-1:0]   ps;
    logic [1:0]             plv;
    logic [1:0]             mat;
    logic                   d;
    logic                   v;

    modport requester (output vppn, va_bit12, asid,
                       input found, index, ppn, ps, plv, mat, d, v);
    modport responder (input vppn, va_bit12, asid,
                       output found, index, ppn, ps, plv, mat, d, v);
endinterface

//--- tlb_array.sv
// TLB entry storage with one write port, one read port and two combinational search ports
`timescale 1ns/1ps
`include "tlb_selftest_config.svh"

module tlb_array (
    input logic              clk_g,
    tlb_write_if.target      wr,
    tlb_read_if.target       rd,
    tlb_search_if.responder  s0,
    tlb_search_if.responder  s1
);
    import tlb_pkg::*;

    // a page word packs ppn, plv, mat, d and v
    localparam int page_w = `TLB_PPN_W + 6;
    // vppn covers va[31:13], so for a 2M page va[21] lands on this vppn bit
    localparam int odd_bit_2m = ps_2m - ps_4k - 1;

    logic                   e_q    [`TLB_NUM];
    logic [`TLB_VPPN_W-1:0] vppn_q [`TLB_NUM];
    logic [`TLB_PS_W-1:0]   ps_q   [`TLB_NUM];
    logic [`TLB_ASID_W-1:0] asid_q [`TLB_NUM];
    logic                   g_q    [`TLB_NUM];
    logic [page_w-1:0]      page0_q [`TLB_NUM];
    logic [page_w-1:0]      page1_q [`TLB_NUM];

    logic [`TLB_NUM-1:0]    s0_hits;
    logic [`TLB_NUM-1:0]    s1_hits;

    always_ff @(posedge clk_g) begin
        if (wr.we) begin
            e_q[wr.index]     <= wr.e;
            vppn_q[wr.index]  <= wr.vppn;
            ps_q[wr.index]    <= wr.ps;
            asid_q[wr.index]  <= wr.asid;
            g_q[wr.index]     <= wr.g;
            page0_q[wr.index] <= {wr.ppn0, wr.plv0, wr.mat0, wr.d0, wr.v0};
            page1_q[wr.index] <= {wr.ppn1, wr.plv1, wr.mat1, wr.d1, wr.v1};
        end
    end

    assign rd.e    = e_q[rd.index];
    assign rd.vppn = vppn_q[rd.index];
    assign rd.ps   = ps_q[rd.index];
    assign rd.asid = asid_q[rd.index];
    assign rd.g    = g_q[rd.index];
    assign {rd.ppn0, rd.plv0, rd.mat0, rd.d0, rd.v0} = page0_q[rd.index];
    assign {rd.ppn1, rd.plv1, rd.mat1, rd.d1, rd.v1} = page1_q[rd.index];

    // 2M entries ignore the vppn bits at and below the odd-page bit
    function automatic logic [`TLB_NUM-1:0] match_vec(input logic [`TLB_VPPN_W-1:0] vppn,
                                                      input logic [`TLB_ASID_W-1:0] asid);
        logic [`TLB_NUM-1:0] m;
        for (int i = 0; i < `TLB_NUM; i++) begin
            m[i] = e_q[i] && (g_q[i] || (asid_q[i] == asid)) &&
                   ((ps_q[i] == ps_2m) ?
                    (vppn_q[i][`TLB_VPPN_W-1:odd_bit_2m+1] == vppn[`TLB_VPPN_W-1:odd_bit_2m+1]) :
                    (vppn_q[i] == vppn));
        end
        return m;
    endfunction

    // lowest hitting index wins
    function automatic logic [tlb_idx_w-1:0] first_hit(input logic [`TLB_NUM-1:0] m);
        logic [tlb_idx_w-1:0] idx;
        idx = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = tlb_idx_w'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [page_w-1:0] page_of(input logic [tlb_idx_w-1:0] idx,
                                                  input logic [`TLB_VPPN_W-1:0] vppn,
                                                  input logic va_bit12);
        logic odd;
        odd = (ps_q[idx] == ps_2m) ? vppn[odd_bit_2m] : va_bit12;
        return odd ? page1_q[idx] : page0_q[idx];
    endfunction

    always_comb begin
        s0_hits  = match_vec(s0.vppn, s0.asid);
        s0.found = |s0_hits;
        s0.index = first_hit(s0_hits);
        s0.ps    = ps_q[s0.index];
        {s0.ppn, s0.plv, s0.mat, s0.d, s0.v} = page_of(s0.index, s0.vppn, s0.va_bit12);
    end

    always_comb begin
        s1_hits  = match_vec(s1.vppn, s1.asid);
        s1.found = |s1_hits;
        s1.index = first_hit(s1_hits);
        s1.ps    = ps_q[s1.index];
        {s1.ppn, s1.plv, s1.mat, s1.d, s1.v} = page_of(s1.index, s1.vppn, s1.va_bit12);
    end

endmodule

//--- tlb_entry_check.sv
// paced write of the 16-entry table into the TLB and read-back comparison against it
`timescale 1ns/1ps
`include "tlb_selftest_config.svh"

module tlb_entry_check (
    input  logic         clk_g,
    input  logic         resetn,
    tlb_write_if.source  wr,
    tlb_read_if.source   rd,
    input  logic         test_error,
    output logic         tick,
    output logic         write_done,
    output logic         read_done,
    output logic         read_error
);
    import tlb_pkg::*;

    localparam int pace_w  = $clog2(`TLB_PACE_RELOAD + 1);
    localparam int entry_w = 2 + `TLB_VPPN_W + `TLB_PS_W + `TLB_ASID_W + 2 * (`TLB_PPN_W + 6);
    localparam logic [tlb_idx_w-1:0] last_row = tlb_idx_w'(`TLB_NUM - 1);

    // every page has plv 0, mat 1, d 1, v 1
    localparam logic [5:0] page_attr = {2'd0, 2'd1, 1'b1, 1'b1};

    // row 0 on the left; rows 0 and 15 are 2M pages, rows 1 and 3 are global
    localparam logic [0:`TLB_NUM-1] huge_rows   = 16'b1000_0000_0000_0001;
    localparam logic [0:`TLB_NUM-1] global_rows = 16'b0101_0000_0000_0000;

    localparam logic [`TLB_VPPN_W-1:0] vppn_tab [`TLB_NUM] = '{
        19'h1000, 19'h111, 19'h222, 19'h333, 19'h444, 19'h444, 19'h666, 19'h666,
        19'h888, 19'h999, 19'haaa, 19'hbbb, 19'hccc, 19'hddd, 19'heee, 19'hf000};
    localparam logic [`TLB_PPN_W-1:0] ppn0_tab [`TLB_NUM] = '{
        20'h1000, 20'h222, 20'h333, 20'h444, 20'h555, 20'h666, 20'h777, 20'h888,
        20'h999, 20'haaa, 20'hbbb, 20'hccc, 20'hddd, 20'heee, 20'hfff, 20'h2000};
    localparam logic [`TLB_PPN_W-1:0] ppn1_tab [`TLB_NUM] = '{
        20'h1100, 20'h033, 20'h044, 20'h055, 20'h066, 20'h077, 20'h088, 20'h099,
        20'h0aa, 20'h0bb, 20'h0cc, 20'h0dd, 20'h0ee, 20'h0ff, 20'h000, 20'h2100};

    logic [pace_w-1:0]    pace_q;
    logic [tlb_idx_w-1:0] wr_row;
    logic [tlb_idx_w-1:0] rd_row;

    // a whole entry in write-port field order, asid follows the row number
    function automatic logic [entry_w-1:0] entry_of(input logic [tlb_idx_w-1:0] row);
        logic [`TLB_PS_W-1:0] ps;
        ps = huge_rows[row] ? ps_2m : ps_4k;
        return {1'b1, vppn_tab[row], ps, `TLB_ASID_W'(row), global_rows[row],
                ppn0_tab[row], page_attr, ppn1_tab[row], page_attr};
    endfunction

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            pace_q <= pace_w'(`TLB_PACE_RELOAD);
        end else if (tick) begin
            pace_q <= pace_w'(`TLB_PACE_RELOAD);
        end else begin
            pace_q <= pace_q - 1'b1;
        end
    end

    assign tick = (pace_q == '0);

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            wr_row     <= '0;
            write_done <= 1'b0;
        end else if (wr_row == last_row) begin
            write_done <= 1'b1;
        end else if (tick) begin
            wr_row <= wr_row + 1'b1;
        end
    end

    // a read mismatch holds the row so the failing entry stays on the port
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            rd_row    <= '0;
            read_done <= 1'b0;
        end else if (write_done && !read_done) begin
            if (rd_row == last_row && !read_error) begin
                read_done <= 1'b1;
            end else if (tick && !test_error && !read_error) begin
                rd_row <= rd_row + 1'b1;
            end
        end
    end

    assign wr.we    = ~write_done;
    assign wr.index = wr_row;
    assign {wr.e, wr.vppn, wr.ps, wr.asid, wr.g,
            wr.ppn0, wr.plv0, wr.mat0, wr.d0, wr.v0,
            wr.ppn1, wr.plv1, wr.mat1, wr.d1, wr.v1} = entry_of(wr_row);

    assign rd.index   = rd_row;
    assign read_error = {rd.e, rd.vppn, rd.ps, rd.asid, rd.g,
                         rd.ppn0, rd.plv0, rd.mat0, rd.d0, rd.v0,
                         rd.ppn1, rd.plv1, rd.mat1, rd.d1, rd.v1} != entry_of(rd_row);

endmodule

//--- tlb_search_status.sv
// paired lookups on both search ports against expected translations, plus error flag and LEDs
`timescale 1ns/1ps
`include "tlb_selftest_config.svh"

module tlb_search_status (
    input  logic                       clk_g,
    input  logic                       resetn,
    input  logic                       tick,
    input  logic                       write_done,
    input  logic                       read_done,
    input  logic                       read_error,
    tlb_search_if.requester            s0,
    tlb_search_if.requester            s1,
    output logic                       test_error,
    output logic [tlb_pkg::led_w-1:0]  led
);
    import tlb_pkg::*;

    localparam int pair_num = 13;
    localparam int pair_w   = $clog2(pair_num);
    localparam int row_num  = 2 * pair_num;

    // expected plv 0, mat 1, d 1, v 1 on every hit
    localparam logic [5:0] page_attr = {2'd0, 2'd1, 1'b1, 1'b1};

    // bit vectors below read left to right in row order
    localparam logic [0:row_num-1] s_va12  = 26'b1011_0000_1001_0110_0101_0100_01;
    localparam logic [0:row_num-1] s_found = 26'b1101_1011_1110_1100_1111_1111_00;
    localparam logic [0:row_num-1] s_huge  = 26'b1100_0000_0000_0000_0000_0001_00;

    localparam logic [`TLB_VPPN_W-1:0] s_vppn [row_num] = '{
        19'h1000, 19'h1100, 19'h1000, 19'h111, 19'h111, 19'h222, 19'h222, 19'h333,
        19'h333, 19'h444, 19'h444, 19'h555, 19'h666, 19'h666, 19'h666, 19'h777,
        19'h888, 19'h999, 19'haaa, 19'hbbb, 19'hccc, 19'hddd, 19'heee, 19'hf000,
        19'habc, 19'h123};
    localparam logic [`TLB_ASID_W-1:0] s_asid [row_num] = '{
        10'h0, 10'h0, 10'h1, 10'h0, 10'h1, 10'h0, 10'h2, 10'h3, 10'h4, 10'h4,
        10'h5, 10'h5, 10'h6, 10'h7, 10'h8, 10'h7, 10'h8, 10'h9, 10'ha, 10'hb,
        10'hc, 10'hd, 10'he, 10'hf, 10'hf, 10'h3};
    // index and ppn of a miss row are never compared
    localparam logic [tlb_idx_w-1:0] s_index [row_num] = '{
        4'h0, 4'h0, 4'h0, 4'h1, 4'h1, 4'h0, 4'h2, 4'h3, 4'h3, 4'h4, 4'h5, 4'h0, 4'h6,
        4'h7, 4'h0, 4'h0, 4'h8, 4'h9, 4'ha, 4'hb, 4'hc, 4'hd, 4'he, 4'hf, 4'h0, 4'h0};
    localparam logic [`TLB_PPN_W-1:0] s_ppn [row_num] = '{
        20'h1000, 20'h1100, 20'h0, 20'h033, 20'h222, 20'h0, 20'h333, 20'h444,
        20'h055, 20'h555, 20'h666, 20'h0, 20'h777, 20'h099, 20'h0, 20'h0,
        20'h999, 20'h0bb, 20'hbbb, 20'h0dd, 20'hddd, 20'h0ff, 20'hfff, 20'h2000,
        20'h0, 20'h0};

    logic [pair_w-1:0] pair_q;
    logic [pair_w:0]   row0;
    logic [pair_w:0]   row1;
    logic              s0_err;
    logic              s1_err;
    logic              search_done;

    function automatic logic mismatch(input logic [pair_w:0] row, input logic found,
                                      input logic [tlb_idx_w-1:0] index,
                                      input logic [`TLB_PPN_W-1:0] ppn,
                                      input logic [`TLB_PS_W-1:0] ps,
                                      input logic [5:0] attr);
        logic [`TLB_PS_W-1:0] exp_ps;
        exp_ps = s_huge[row] ? ps_2m : ps_4k;
        return (found != s_found[row]) ||
               (s_found[row] &&
                ({index, ppn, ps, attr} != {s_index[row], s_ppn[row], exp_ps, page_attr}));
    endfunction

    // pair p puts row 2p on port 0 and row 2p+1 on port 1
    assign row0 = {pair_q, 1'b0};
    assign row1 = {pair_q, 1'b1};

    assign s0.vppn     = s_vppn[row0];
    assign s0.va_bit12 = s_va12[row0];
    assign s0.asid     = s_asid[row0];
    assign s1.vppn     = s_vppn[row1];
    assign s1.va_bit12 = s_va12[row1];
    assign s1.asid     = s_asid[row1];

    assign s0_err = mismatch(row0, s0.found, s0.index, s0.ppn, s0.ps,
                             {s0.plv, s0.mat, s0.d, s0.v});
    assign s1_err = mismatch(row1, s1.found, s1.index, s1.ppn, s1.ps,
                             {s1.plv, s1.mat, s1.d, s1.v});

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            pair_q      <= '0;
            search_done <= 1'b0;
        end else if (write_done && !search_done) begin
            if (pair_q == pair_w'(pair_num - 1) && !s0_err && !s1_err) begin
                search_done <= 1'b1;
            end else if (tick && !test_error && !s0_err && !s1_err) begin
                pair_q <= pair_q + 1'b1;
            end
        end
    end

    // sticky until the next reset
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            test_error <= 1'b0;
        end else if (write_done && ((!read_done && read_error) ||
                                    (!search_done && (s0_err || s1_err)))) begin
            test_error <= 1'b1;
        end
    end

    // LEDs are active low
    assign led = {~test_error, {(led_w - 4){1'b1}}, ~write_done, ~read_done, ~search_done};

endmodule

//--- tlb_selftest_top.sv
// board top of the TLB self-test, the TLB array and its two checkers driving four status LEDs
`timescale 1ns/1ps

module tlb_selftest_top (
    input  logic        clk_g,
    input  logic        resetn,
    output logic [15:0] led
);

    logic tick;
    logic write_done;
    logic read_done;
    logic read_error;
    logic test_error;

    tlb_write_if  wr_if ();
    tlb_read_if   rd_if ();
    tlb_search_if s0_if ();
    tlb_search_if s1_if ();

    tlb_array u_array (
        .clk_g (clk_g),
        .wr    (wr_if.target),
        .rd    (rd_if.target),
        .s0    (s0_if.responder),
        .s1    (s1_if.responder)
    );

    tlb_entry_check u_entry_check (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .wr         (wr_if.source),
        .rd         (rd_if.source),
        .test_error (test_error),
        .tick       (tick),
        .write_done (write_done),
        .read_done  (read_done),
        .read_error (read_error)
    );

    tlb_search_status u_search_status (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .tick       (tick),
        .write_done (write_done),
        .read_done  (read_done),
        .read_error (read_error),
        .s0         (s0_if.requester),
        .s1         (s1_if.requester),
        .test_error (test_error),
        .led        (led)
    );

endmodule

//--- tlb_selftest_props.sv
// concurrent assertions on the self-test status, bound into every tlb_search_status instance
`timescale 1ns/1ps

module tlb_selftest_props (
    input logic                       clk_g,
    input logic                       resetn,
    input logic                       test_error,
    input logic                       write_done,
    input logic                       read_done,
    input logic [tlb_pkg::led_w-1:0]  led
);

    // the testbench adds this count to its own error total
    int fail_count = 0;

    no_test_error: assert property (@(posedge clk_g) disable iff (!resetn) !test_error)
        else begin
            $error("test_error rose during the self-test");
            fail_count++;
        end

    read_after_write: assert property (@(posedge clk_g) disable iff (!resetn)
                                       read_done |-> write_done)
        else begin
            $error("read_done is set while write_done is still clear");
            fail_count++;
        end

    // bits 14 to 3 carry no status and stay dark
    idle_leds_high: assert property (@(posedge clk_g) disable iff (!resetn)
                                     led[14:3] == 12'hfff)
        else begin
            $error("led bits 14 to 3 left the all-ones state");
            fail_count++;
        end

endmodule

bind tlb_search_status tlb_selftest_props u_props (
    .clk_g      (clk_g),
    .resetn     (resetn),
    .test_error (test_error),
    .write_done (write_done),
    .read_done  (read_done),
    .led        (led)
);

//--- tb_led_monitor.sv
// led checker for the self-test testbench, compares checkpoints and the fixed bits on every cycle
`timescale 1ns/1ps

module tb_led_monitor (
    input  logic        clk_g,
    input  logic        resetn,
    input  logic [15:0] led,
    input  logic        check_en,
    input  logic [15:0] exp_led,
    output int          errors,
    output int          checks
);

    logic seen_reset;

    initial begin
        errors     = 0;
        checks     = 0;
        seen_reset = 1'b0;
    end

    // led is sampled before the registers behind it update on this edge
    always @(posedge clk_g) begin
        if (seen_reset && (led[15] !== 1'b1 || led[14:3] !== 12'hfff)) begin
            $display("ERR %0t led expected %h actual %h", $time,
                     {1'b1, 12'hfff, led[2:0]}, led);
            errors++;
        end
        if (check_en) begin
            checks++;
            if (led !== exp_led) begin
                $display("ERR %0t led expected %h actual %h", $time, exp_led, led);
                errors++;
            end
        end
        // fixed bits are only defined once a reset edge has been seen
        seen_reset <= seen_reset || !resetn;
    end

endmodule

//--- tb_tlb_selftest.sv
// testbench for the TLB self-test board top, runs led checkpoints across three reset passes
`timescale 1ns/1ps

module tb_tlb_selftest;

    localparam int row_num   = 14;
    localparam int reset_len = 16;

    logic        clk_g;
    logic        resetn;
    logic [15:0] led;
    logic        check_en;
    logic [15:0] exp_led;
    int          mon_errors;
    int          mon_checks;

    // checkpoint table, cycles counted from reset release
    bit          row_rst [row_num];
    int          row_cyc [row_num];
    logic [15:0] row_exp [row_num];

    tlb_selftest_top uut (
        .clk_g  (clk_g),
        .resetn (resetn),
        .led    (led)
    );

    tb_led_monitor u_monitor (
        .clk_g    (clk_g),
        .resetn   (resetn),
        .led      (led),
        .check_en (check_en),
        .exp_led  (exp_led),
        .errors   (mon_errors),
        .checks   (mon_checks)
    );

    task automatic set_row(input int i, input bit rst, input int cyc, input logic [15:0] exp);
        row_rst[i] = rst;
        row_cyc[i] = cyc;
        row_exp[i] = exp;
    endtask

    function automatic int watchdog_cycles();
        int total;
        total = 50;
        for (int i = 0; i < row_num; i++) begin
            total += row_cyc[i] + (row_rst[i] ? reset_len : 0);
        end
        return total;
    endfunction

    initial begin
        clk_g = 1'b0;
        forever #20 clk_g = ~clk_g;
    end

    initial begin
        resetn   = 1'b0;
        check_en = 1'b0;
        exp_led  = 16'hffff;
        // full pass: write done at 90, search done at 162, read done at 180
        set_row(0, 1'b1, 0, 16'hffff);
        set_row(1, 1'b0, 80, 16'hffff);
        set_row(2, 1'b0, 100, 16'hfffb);
        set_row(3, 1'b0, 170, 16'hfffa);
        set_row(4, 1'b0, 190, 16'hfff8);
        // partial pass, cut off by the reset of the next row
        set_row(5, 1'b1, 0, 16'hffff);
        set_row(6, 1'b0, 80, 16'hffff);
        set_row(7, 1'b0, 100, 16'hfffb);
        set_row(8, 1'b0, 130, 16'hfffb);
        set_row(9, 1'b1, 0, 16'hffff);
        set_row(10, 1'b0, 80, 16'hffff);
        set_row(11, 1'b0, 100, 16'hfffb);
        set_row(12, 1'b0, 170, 16'hfffa);
        set_row(13, 1'b0, 190, 16'hfff8);
    end

    // main sequence, inputs change on the falling edge only
    initial begin
        int cyc;
        int total;
        #1;
        cyc = 0;
        for (int i = 0; i < row_num; i++) begin
            if (row_rst[i]) begin
                @(negedge clk_g);
                resetn = 1'b0;
                repeat (reset_len) @(negedge clk_g);
                resetn = 1'b1;
                cyc = 0;
            end
            while (cyc < row_cyc[i]) begin
                @(negedge clk_g);
                cyc++;
            end
            exp_led  = row_exp[i];
            check_en = 1'b1;
            @(negedge clk_g);
            cyc++;
            check_en = 1'b0;
        end
        @(negedge clk_g);
        total = mon_errors + uut.u_search_status.u_props.fail_count;
        $display("%0d checkpoints, %0d led errors, %0d assertion failures",
                 mon_checks, mon_errors, uut.u_search_status.u_props.fail_count);
        if (total == 0 && mon_checks == row_num) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        #1;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk_g);
        $display("the run timed out after %0d cycles before all checkpoints were reached", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tlb_selftest.f
+incdir+.
tlb_pkg.sv
tlb_ports_if.sv
tlb_array.sv
tlb_entry_check.sv
tlb_search_status.sv
tlb_selftest_top.sv
tlb_selftest_props.sv
tb_led_monitor.sv
tb_tlb_selftest.sv
